// File: src/cachePkg.sv
// cache package with coherence states, snoop opcodes and default widths
package cachePkg;

	// default geometry, passed down from the top level
	localparam int TAG_WIDTH   = 8;
	localparam int INDEX_WIDTH = 3;
	localparam int WAYS_LOG2   = 1;
	localparam int DATA_WIDTH  = 32;

	// coherence state of one line
	typedef enum logic [1:0] {
		stateInvalid  = 2'b00,
		stateShared   = 2'b01,
		stateModified = 2'b10
	} lineState;

	// request kinds arriving from other caches
	typedef enum logic {
		snoopRead       = 1'b0,
		snoopInvalidate = 1'b1
	} snoopOp;

endpackage

// File: src/cacheIf.sv
// cache interface carrying lookups and writes between the port modules and the core
`timescale 1ns/1ps

interface cacheIf #(
	parameter int TAG_WIDTH   = cachePkg::TAG_WIDTH,
	parameter int INDEX_WIDTH = cachePkg::INDEX_WIDTH,
	parameter int WAYS_LOG2   = cachePkg::WAYS_LOG2,
	parameter int DATA_WIDTH  = cachePkg::DATA_WIDTH
);

	// cpu side lookup and write
	logic [INDEX_WIDTH-1:0] cpuIndex;
	logic [TAG_WIDTH-1:0]   cpuTag;
	logic [DATA_WIDTH-1:0]  cpuData;
	logic                   cpuWriteLine;
	logic                   cpuAccess;
	logic                   cpuHit;
	logic [DATA_WIDTH-1:0]  cpuDataOut;
	logic [WAYS_LOG2-1:0]   cpuWay;

	// snoop side lookup and state change
	logic [INDEX_WIDTH-1:0] snoopIndex;
	logic [TAG_WIDTH-1:0]   snoopTag;
	logic                   snoopWriteState;
	cachePkg::lineState     snoopStateIn;
	logic                   snoopInvalidate;
	logic                   snoopHit;
	logic [DATA_WIDTH-1:0]  snoopDataOut;
	cachePkg::lineState     snoopStateOut;

	modport core (
		input  cpuIndex, cpuTag, cpuData, cpuWriteLine, cpuAccess,
		input  snoopIndex, snoopTag, snoopWriteState, snoopStateIn, snoopInvalidate,
		output cpuHit, cpuDataOut, cpuWay,
		output snoopHit, snoopDataOut, snoopStateOut
	);

	modport cpu (
		output cpuIndex, cpuTag, cpuData, cpuWriteLine, cpuAccess,
		input  cpuHit, cpuDataOut
	);

	modport snoop (
		output snoopIndex, snoopTag, snoopWriteState, snoopStateIn, snoopInvalidate,
		input  snoopHit, snoopDataOut, snoopStateOut
	);

endinterface

// File: src/directMappedWay.sv
// direct-mapped cache way holding tag, data and coherence state for every set
`timescale 1ns/1ps

module directMappedWay #(
	parameter int TAG_WIDTH   = cachePkg::TAG_WIDTH,
	parameter int INDEX_WIDTH = cachePkg::INDEX_WIDTH,
	parameter int DATA_WIDTH  = cachePkg::DATA_WIDTH
) (
	input  logic                   clock,
	input  logic                   rstN,
	input  logic [INDEX_WIDTH-1:0] cpuIndex,
	input  logic [TAG_WIDTH-1:0]   cpuTag,
	input  logic [DATA_WIDTH-1:0]  cpuDataIn,
	input  logic                   cpuWrite,
	input  logic [INDEX_WIDTH-1:0] snoopIndex,
	input  logic [TAG_WIDTH-1:0]   snoopTag,
	input  logic                   snoopWrite,
	input  cachePkg::lineState     snoopStateIn,
	output logic                   cpuHit,
	output logic [DATA_WIDTH-1:0]  cpuDataOut,
	output logic                   snoopHit,
	output logic [DATA_WIDTH-1:0]  snoopDataOut,
	output cachePkg::lineState     snoopStateOut
);

	localparam int SETS = 1 << INDEX_WIDTH;

	logic [TAG_WIDTH-1:0]  tags   [SETS];
	logic [DATA_WIDTH-1:0] data   [SETS];
	cachePkg::lineState    states [SETS];

	// tag and data storage, written only by the cpu side
	always_ff @(posedge clock) begin
		if (cpuWrite) begin
			tags[cpuIndex] <= cpuTag;
			data[cpuIndex] <= cpuDataIn;
		end
	end

	// state array, snoop write last so it wins on the same entry
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int s = 0; s < SETS; s++) begin
				states[s] <= cachePkg::stateInvalid;
			end
		end else begin
			if (cpuWrite) begin
				states[cpuIndex] <= cachePkg::stateModified;
			end
			if (snoopWrite) begin
				states[snoopIndex] <= snoopStateIn;
			end
		end
	end

	// hit needs a matching tag on a valid line
	assign cpuHit   = (tags[cpuIndex] == cpuTag) && (states[cpuIndex] != cachePkg::stateInvalid);
	assign snoopHit = (tags[snoopIndex] == snoopTag)
		&& (states[snoopIndex] != cachePkg::stateInvalid);

	assign cpuDataOut    = data[cpuIndex];
	assign snoopDataOut  = data[snoopIndex];
	assign snoopStateOut = states[snoopIndex];

endmodule

// File: src/lruTracker.sv
// LRU tracker keeping per-set way ages and naming the replacement way
`timescale 1ns/1ps

module lruTracker #(
	parameter int INDEX_WIDTH = cachePkg::INDEX_WIDTH,
	parameter int WAYS_LOG2   = cachePkg::WAYS_LOG2
) (
	input  logic                   clock,
	input  logic                   rstN,
	input  logic [INDEX_WIDTH-1:0] accessIndex,
	input  logic [WAYS_LOG2-1:0]   accessWay,
	input  logic                   accessEnable,
	input  logic [INDEX_WIDTH-1:0] invalidateIndex,
	input  logic [WAYS_LOG2-1:0]   invalidateWay,
	input  logic                   invalidateEnable,
	output logic [WAYS_LOG2-1:0]   replacementWay
);

	localparam int SETS = 1 << INDEX_WIDTH;
	localparam int WAYS = 1 << WAYS_LOG2;

	// age 0 is youngest, WAYS-1 is oldest
	logic [WAYS_LOG2-1:0] ages [SETS][WAYS];

	always_ff @(posedge clock) begin
		if (!rstN) begin
			// way 0 starts oldest
			for (int s = 0; s < SETS; s++) begin
				for (int w = 0; w < WAYS; w++) begin
					ages[s][w] <= WAYS_LOG2'(WAYS - 1 - w);
				end
			end
		end else if (accessEnable) begin
			for (int w = 0; w < WAYS; w++) begin
				if (WAYS_LOG2'(w) == accessWay) begin
					ages[accessIndex][w] <= '0;
				end else if (ages[accessIndex][w] < ages[accessIndex][accessWay]) begin
					ages[accessIndex][w] <= ages[accessIndex][w] + 1'b1;
				end
			end
		end else if (invalidateEnable) begin
			// invalidated way drops to the back of the queue
			for (int w = 0; w < WAYS; w++) begin
				if (WAYS_LOG2'(w) == invalidateWay) begin
					ages[invalidateIndex][w] <= WAYS_LOG2'(WAYS - 1);
				end else if (ages[invalidateIndex][w] > ages[invalidateIndex][invalidateWay]) begin
					ages[invalidateIndex][w] <= ages[invalidateIndex][w] - 1'b1;
				end
			end
		end
	end

	// oldest way wins, lowest number on a tie
	always_comb begin
		replacementWay = '0;
		for (int w = 1; w < WAYS; w++) begin
			if (ages[accessIndex][w] > ages[accessIndex][replacementWay]) begin
				replacementWay = WAYS_LOG2'(w);
			end
		end
	end

endmodule

// File: src/setAssociativeCache.sv
// set-associative cache core built from direct-mapped ways and an LRU tracker
`timescale 1ns/1ps

module setAssociativeCache #(
	parameter int TAG_WIDTH   = cachePkg::TAG_WIDTH,
	parameter int INDEX_WIDTH = cachePkg::INDEX_WIDTH,
	parameter int WAYS_LOG2   = cachePkg::WAYS_LOG2,
	parameter int DATA_WIDTH  = cachePkg::DATA_WIDTH
) (
	input logic   clock,
	input logic   rstN,
	cacheIf.core  ifc
);

	localparam int WAYS = 1 << WAYS_LOG2;

	logic [WAYS-1:0]       cpuHits;
	logic [WAYS-1:0]       snoopHits;
	logic [DATA_WIDTH-1:0] cpuDataOuts   [WAYS];
	logic [DATA_WIDTH-1:0] snoopDataOuts [WAYS];
	cachePkg::lineState    snoopStateOuts [WAYS];
	logic [WAYS_LOG2-1:0]  cpuHitWay;
	logic [WAYS_LOG2-1:0]  snoopHitWay;
	logic [WAYS_LOG2-1:0]  replacementWay;
	logic [WAYS_LOG2-1:0]  writeWay;
	logic                  anyCpuHit;
	logic                  anySnoopHit;

	for (genvar w = 0; w < WAYS; w++) begin : gWay
		directMappedWay #(
			.TAG_WIDTH(TAG_WIDTH),
			.INDEX_WIDTH(INDEX_WIDTH),
			.DATA_WIDTH(DATA_WIDTH)
		) wayInst (
			.clock(clock),
			.rstN(rstN),
			.cpuIndex(ifc.cpuIndex),
			.cpuTag(ifc.cpuTag),
			.cpuDataIn(ifc.cpuData),
			.cpuWrite(ifc.cpuWriteLine && (writeWay == WAYS_LOG2'(w))),
			.snoopIndex(ifc.snoopIndex),
			.snoopTag(ifc.snoopTag),
			.snoopWrite(ifc.snoopWriteState && snoopHits[w]),
			.snoopStateIn(ifc.snoopStateIn),
			.cpuHit(cpuHits[w]),
			.cpuDataOut(cpuDataOuts[w]),
			.snoopHit(snoopHits[w]),
			.snoopDataOut(snoopDataOuts[w]),
			.snoopStateOut(snoopStateOuts[w])
		);
	end

	// hit encoders, at most one way hits per lookup
	always_comb begin
		cpuHitWay   = '0;
		snoopHitWay = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (cpuHits[w]) begin
				cpuHitWay = WAYS_LOG2'(w);
			end
			if (snoopHits[w]) begin
				snoopHitWay = WAYS_LOG2'(w);
			end
		end
	end

	assign anyCpuHit   = |cpuHits;
	assign anySnoopHit = |snoopHits;

	// write to the hitting way, else replace the oldest
	assign writeWay = anyCpuHit ? cpuHitWay : replacementWay;

	lruTracker #(
		.INDEX_WIDTH(INDEX_WIDTH),
		.WAYS_LOG2(WAYS_LOG2)
	) lruInst (
		.clock(clock),
		.rstN(rstN),
		.accessIndex(ifc.cpuIndex),
		.accessWay(writeWay),
		.accessEnable(ifc.cpuAccess && (anyCpuHit || ifc.cpuWriteLine)),
		.invalidateIndex(ifc.snoopIndex),
		.invalidateWay(snoopHitWay),
		.invalidateEnable(ifc.snoopInvalidate && anySnoopHit),
		.replacementWay(replacementWay)
	);

	// output muxes by way number
	assign ifc.cpuHit        = anyCpuHit;
	assign ifc.cpuWay        = cpuHitWay;
	assign ifc.cpuDataOut    = cpuDataOuts[cpuHitWay];
	assign ifc.snoopHit      = anySnoopHit;
	assign ifc.snoopDataOut  = snoopDataOuts[snoopHitWay];
	assign ifc.snoopStateOut = snoopStateOuts[snoopHitWay];

endmodule

// File: src/cpuPort.sv
// Wishbone classic slave sequencing single-word CPU reads and writes into the cache
`timescale 1ns/1ps

module cpuPort #(
	parameter int TAG_WIDTH   = cachePkg::TAG_WIDTH,
	parameter int INDEX_WIDTH = cachePkg::INDEX_WIDTH,
	parameter int DATA_WIDTH  = cachePkg::DATA_WIDTH
) (
	input  logic                             clock,
	input  logic                             rstN,
	input  logic                             wbCyc,
	input  logic                             wbStb,
	input  logic                             wbWe,
	input  logic [TAG_WIDTH+INDEX_WIDTH-1:0] wbAdr,
	input  logic [DATA_WIDTH-1:0]            wbDatW,
	input  logic                             snoopBusy,
	output logic [DATA_WIDTH-1:0]            wbDatR,
	output logic                             wbAck,
	output logic                             wbErr,
	cacheIf.cpu                              ifc
);

	typedef enum logic {idle, respond} portState;

	portState state;
	logic     request;
	logic     complete;
	// set after a response until the master drops stb
	logic     served;

	assign request  = wbCyc && wbStb;
	// snoops own the arrays while snoopBusy is high
	assign complete = (state == respond) && request && !snoopBusy;

	assign ifc.cpuIndex     = wbAdr[INDEX_WIDTH-1:0];
	assign ifc.cpuTag       = wbAdr[INDEX_WIDTH +: TAG_WIDTH];
	assign ifc.cpuData      = wbDatW;
	assign ifc.cpuAccess    = complete;
	assign ifc.cpuWriteLine = complete && wbWe;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state  <= idle;
			wbAck  <= 1'b0;
			wbErr  <= 1'b0;
			served <= 1'b0;
		end else begin
			// read miss is the only error
			wbAck <= complete && (wbWe || ifc.cpuHit);
			wbErr <= complete && !wbWe && !ifc.cpuHit;
			if (complete) begin
				served <= 1'b1;
			end else if (!wbStb) begin
				served <= 1'b0;
			end
			case (state)
				idle: begin
					if (request && !served && !snoopBusy) begin
						state <= respond;
					end
				end
				respond: begin
					if (complete || !request) begin
						state <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (complete && !wbWe) begin
			wbDatR <= ifc.cpuDataOut;
		end
	end

endmodule

// File: src/snoopPort.sv
// snoop port applying coherence state changes and returning registered responses
`timescale 1ns/1ps

module snoopPort #(
	parameter int TAG_WIDTH   = cachePkg::TAG_WIDTH,
	parameter int INDEX_WIDTH = cachePkg::INDEX_WIDTH,
	parameter int DATA_WIDTH  = cachePkg::DATA_WIDTH
) (
	input  logic                             clock,
	input  logic                             rstN,
	input  logic                             snoopValid,
	input  cachePkg::snoopOp                 snoopOpIn,
	input  logic [TAG_WIDTH+INDEX_WIDTH-1:0] snoopAdr,
	output logic                             snoopDone,
	output logic                             snoopHit,
	output logic [DATA_WIDTH-1:0]            snoopData,
	cacheIf.snoop                            ifc
);

	cachePkg::lineState newState;

	assign ifc.snoopIndex = snoopAdr[INDEX_WIDTH-1:0];
	assign ifc.snoopTag   = snoopAdr[INDEX_WIDTH +: TAG_WIDTH];

	// a read downgrades a valid line to shared, an invalidate drops it
	always_comb begin
		if (snoopOpIn == cachePkg::snoopInvalidate) begin
			newState = cachePkg::stateInvalid;
		end else if (ifc.snoopStateOut != cachePkg::stateInvalid) begin
			newState = cachePkg::stateShared;
		end else begin
			newState = ifc.snoopStateOut;
		end
	end

	assign ifc.snoopStateIn    = newState;
	assign ifc.snoopWriteState = snoopValid && ifc.snoopHit;
	assign ifc.snoopInvalidate = snoopValid && (snoopOpIn == cachePkg::snoopInvalidate);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			snoopDone <= 1'b0;
			snoopHit  <= 1'b0;
		end else begin
			snoopDone <= snoopValid;
			if (snoopValid) begin
				snoopHit <= ifc.snoopHit;
			end
		end
	end

	// zero data on a miss
	always_ff @(posedge clock) begin
		if (snoopValid) begin
			snoopData <= ifc.snoopHit ? ifc.snoopDataOut : '0;
		end
	end

endmodule

// File: src/cacheTop.sv
// cache top level joining the Wishbone port, the snoop port and the cache core
`timescale 1ns/1ps

module cacheTop #(
	parameter int TAG_WIDTH   = cachePkg::TAG_WIDTH,
	parameter int INDEX_WIDTH = cachePkg::INDEX_WIDTH,
	parameter int WAYS_LOG2   = cachePkg::WAYS_LOG2,
	parameter int DATA_WIDTH  = cachePkg::DATA_WIDTH
) (
	input  logic                             clock,
	input  logic                             rstN,
	input  logic                             wbCyc,
	input  logic                             wbStb,
	input  logic                             wbWe,
	input  logic [TAG_WIDTH+INDEX_WIDTH-1:0] wbAdr,
	input  logic [DATA_WIDTH-1:0]            wbDatW,
	output logic [DATA_WIDTH-1:0]            wbDatR,
	output logic                             wbAck,
	output logic                             wbErr,
	input  logic                             snoopValid,
	input  cachePkg::snoopOp                 snoopOpIn,
	input  logic [TAG_WIDTH+INDEX_WIDTH-1:0] snoopAdr,
	output logic                             snoopDone,
	output logic                             snoopHit,
	output logic [DATA_WIDTH-1:0]            snoopData
);

	cacheIf #(
		.TAG_WIDTH(TAG_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.WAYS_LOG2(WAYS_LOG2),
		.DATA_WIDTH(DATA_WIDTH)
	) bus ();

	cpuPort #(
		.TAG_WIDTH(TAG_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) cpuPortInst (
		.clock(clock),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		// snoops take priority over cpu requests
		.snoopBusy(snoopValid),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.wbErr(wbErr),
		.ifc(bus.cpu)
	);

	snoopPort #(
		.TAG_WIDTH(TAG_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) snoopPortInst (
		.clock(clock),
		.rstN(rstN),
		.snoopValid(snoopValid),
		.snoopOpIn(snoopOpIn),
		.snoopAdr(snoopAdr),
		.snoopDone(snoopDone),
		.snoopHit(snoopHit),
		.snoopData(snoopData),
		.ifc(bus.snoop)
	);

	setAssociativeCache #(
		.TAG_WIDTH(TAG_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.WAYS_LOG2(WAYS_LOG2),
		.DATA_WIDTH(DATA_WIDTH)
	) coreInst (
		.clock(clock),
		.rstN(rstN),
		.ifc(bus.core)
	);

endmodule

// File: dv/cacheAssert.sv
// bound assertions on the Wishbone handshake, snoop timing and reset quiet period
`timescale 1ns/1ps

module cacheAssert (
	input logic clock,
	input logic rstN,
	input logic wbAck,
	input logic wbErr,
	input logic snoopValid,
	input logic snoopDone
);

	ackErrExclusive: assert property (@(posedge clock) disable iff (!rstN)
		!(wbAck && wbErr))
		else $error("wbAck and wbErr high together");

	// each response lasts a single cycle
	ackOneCycle: assert property (@(posedge clock) disable iff (!rstN)
		wbAck |=> !wbAck)
		else $error("wbAck held for more than one cycle");

	errOneCycle: assert property (@(posedge clock) disable iff (!rstN)
		wbErr |=> !wbErr)
		else $error("wbErr held for more than one cycle");

	snoopDoneFollows: assert property (@(posedge clock) disable iff (!rstN)
		snoopValid |=> snoopDone)
		else $error("snoopDone missing one cycle after snoopValid");

	snoopDoneCause: assert property (@(posedge clock) disable iff (!rstN)
		snoopDone |-> $past(snoopValid))
		else $error("snoopDone without a snoopValid the cycle before");

	// synchronous reset clears every response
	quietInReset: assert property (@(posedge clock)
		!rstN |=> !wbAck && !wbErr && !snoopDone)
		else $error("response raised during reset");

endmodule

bind cacheTop cacheAssert assertInst (
	.clock(clock),
	.rstN(rstN),
	.wbAck(wbAck),
	.wbErr(wbErr),
	.snoopValid(snoopValid),
	.snoopDone(snoopDone)
);

// File: dv/cacheTb.sv
// cache testbench running directed and random Wishbone and snoop traffic against a model
`timescale 1ns/1ps

module cacheTb;

	localparam int TAG_WIDTH   = cachePkg::TAG_WIDTH;
	localparam int INDEX_WIDTH = cachePkg::INDEX_WIDTH;
	localparam int WAYS_LOG2   = cachePkg::WAYS_LOG2;
	localparam int DATA_WIDTH  = cachePkg::DATA_WIDTH;
	localparam int ADR_WIDTH   = TAG_WIDTH + INDEX_WIDTH;
	localparam int SETS        = 1 << INDEX_WIDTH;
	localparam int WAYS        = 1 << WAYS_LOG2;
	localparam int TIMEOUT     = 40;

	// model transaction kinds
	localparam int KIND_READ       = 0;
	localparam int KIND_WRITE      = 1;
	localparam int KIND_SNOOP_READ = 2;
	localparam int KIND_SNOOP_INV  = 3;

	logic                  clock;
	logic                  rstN;
	logic                  wbCyc;
	logic                  wbStb;
	logic                  wbWe;
	logic [ADR_WIDTH-1:0]  wbAdr;
	logic [DATA_WIDTH-1:0] wbDatW;
	logic [DATA_WIDTH-1:0] wbDatR;
	logic                  wbAck;
	logic                  wbErr;
	logic                  snoopValid;
	cachePkg::snoopOp      snoopOpIn;
	logic [ADR_WIDTH-1:0]  snoopAdr;
	logic                  snoopDone;
	logic                  snoopHit;
	logic [DATA_WIDTH-1:0] snoopData;

	// reference model contents
	logic [TAG_WIDTH-1:0]  modelTag   [SETS][WAYS];
	logic [DATA_WIDTH-1:0] modelData  [SETS][WAYS];
	cachePkg::lineState    modelState [SETS][WAYS];
	int                    modelAge   [SETS][WAYS];

	// expected responses in arrival order
	bit                    cpuExpAck [$];
	bit                    cpuExpCheck [$];
	logic [DATA_WIDTH-1:0] cpuExpData [$];
	bit                    snoopExpHit [$];
	logic [DATA_WIDTH-1:0] snoopExpData [$];

	int     errorCount = 0;
	int     timeoutCount = 0;
	integer seed;

	cacheTop #(
		.TAG_WIDTH(TAG_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.WAYS_LOG2(WAYS_LOG2),
		.DATA_WIDTH(DATA_WIDTH)
	) DUT (
		.clock(clock),
		.rstN(rstN),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbWe(wbWe),
		.wbAdr(wbAdr),
		.wbDatW(wbDatW),
		.wbDatR(wbDatR),
		.wbAck(wbAck),
		.wbErr(wbErr),
		.snoopValid(snoopValid),
		.snoopOpIn(snoopOpIn),
		.snoopAdr(snoopAdr),
		.snoopDone(snoopDone),
		.snoopHit(snoopHit),
		.snoopData(snoopData)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	function automatic void resetModel();
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < WAYS; w++) begin
				modelState[s][w] = cachePkg::stateInvalid;
				modelAge[s][w] = WAYS - 1 - w;
			end
		end
	endfunction

	// oldest way wins and a tie goes to the lowest number
	function automatic int oldestWay(input int idx);
		int best;
		best = 0;
		for (int w = 1; w < WAYS; w++) begin
			if (modelAge[idx][w] > modelAge[idx][best]) begin
				best = w;
			end
		end
		return best;
	endfunction

	function automatic void makeYoungest(input int idx, input int way);
		int old;
		old = modelAge[idx][way];
		for (int w = 0; w < WAYS; w++) begin
			if (w != way && modelAge[idx][w] < old) begin
				modelAge[idx][w]++;
			end
		end
		modelAge[idx][way] = 0;
	endfunction

	function automatic void makeOldest(input int idx, input int way);
		int old;
		old = modelAge[idx][way];
		for (int w = 0; w < WAYS; w++) begin
			if (w != way && modelAge[idx][w] > old) begin
				modelAge[idx][w]--;
			end
		end
		modelAge[idx][way] = WAYS - 1;
	endfunction

	// applies one transaction to the model and returns its lookup result
	function automatic void refModel(input int kind, input logic [ADR_WIDTH-1:0] adr,
		input logic [DATA_WIDTH-1:0] wdata, output logic hit, output logic [DATA_WIDTH-1:0] rdata);
		int                   idx;
		int                   hitWay;
		int                   way;
		logic [TAG_WIDTH-1:0] tag;
		idx = int'(adr[INDEX_WIDTH-1:0]);
		tag = adr[INDEX_WIDTH +: TAG_WIDTH];
		hitWay = -1;
		for (int w = 0; w < WAYS; w++) begin
			if (modelState[idx][w] != cachePkg::stateInvalid && modelTag[idx][w] == tag) begin
				hitWay = w;
			end
		end
		hit = (hitWay >= 0);
		rdata = '0;
		if (hit) begin
			rdata = modelData[idx][hitWay];
		end
		case (kind)
			KIND_READ: begin
				if (hit) begin
					makeYoungest(idx, hitWay);
				end
			end
			KIND_WRITE: begin
				way = hit ? hitWay : oldestWay(idx);
				modelTag[idx][way] = tag;
				modelData[idx][way] = wdata;
				modelState[idx][way] = cachePkg::stateModified;
				makeYoungest(idx, way);
			end
			KIND_SNOOP_READ: begin
				if (hit) begin
					modelState[idx][hitWay] = cachePkg::stateShared;
				end
			end
			default: begin
				if (hit) begin
					modelState[idx][hitWay] = cachePkg::stateInvalid;
					makeOldest(idx, hitWay);
				end
			end
		endcase
	endfunction

	function automatic void predictCpu(input logic we, input logic [ADR_WIDTH-1:0] adr,
		input logic [DATA_WIDTH-1:0] data);
		logic                  hit;
		logic [DATA_WIDTH-1:0] rdata;
		refModel(we ? KIND_WRITE : KIND_READ, adr, data, hit, rdata);
		// only a read miss ends in err
		cpuExpAck.push_back(we || hit);
		cpuExpCheck.push_back(!we && hit);
		cpuExpData.push_back(rdata);
	endfunction

	function automatic void predictSnoop(input cachePkg::snoopOp op,
		input logic [ADR_WIDTH-1:0] adr);
		logic                  hit;
		logic [DATA_WIDTH-1:0] rdata;
		refModel(op == cachePkg::snoopInvalidate ? KIND_SNOOP_INV : KIND_SNOOP_READ,
			adr, '0, hit, rdata);
		snoopExpHit.push_back(hit);
		snoopExpData.push_back(rdata);
	endfunction

	function automatic logic [ADR_WIDTH-1:0] randomAdr();
		// few tags per set so hits and evictions both happen
		return {TAG_WIDTH'({$random(seed)} % 4), INDEX_WIDTH'({$random(seed)} % SETS)};
	endfunction

	// one Wishbone transfer with an optional snoop pulse while it waits
	task automatic cpuTransfer(input logic we, input logic [ADR_WIDTH-1:0] adr,
		input logic [DATA_WIDTH-1:0] data, input bit withSnoop, input cachePkg::snoopOp op,
		input logic [ADR_WIDTH-1:0] sAdr, input int holdCycles);
		int cycles;
		// the snoop lands before the cpu request can complete
		if (withSnoop) begin
			predictSnoop(op, sAdr);
		end
		predictCpu(we, adr, data);
		wbCyc  <= 1'b1;
		wbStb  <= 1'b1;
		wbWe   <= we;
		wbAdr  <= adr;
		wbDatW <= data;
		@(posedge clock);
		// pulse falls in the cycle where the port is ready to respond
		if (withSnoop) begin
			snoopValid <= 1'b1;
			snoopOpIn  <= op;
			snoopAdr   <= sAdr;
			@(posedge clock);
			snoopValid <= 1'b0;
		end
		cycles = 0;
		@(negedge clock);
		while (!(wbAck || wbErr) && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!(wbAck || wbErr)) begin
			$display("timeout: no wbAck or wbErr for address 0x%h", adr);
			timeoutCount++;
			cpuExpAck.delete();
			cpuExpCheck.delete();
			cpuExpData.delete();
		end
		// master keeps stb up past the response
		repeat (holdCycles) @(posedge clock);
		@(posedge clock);
		wbCyc <= 1'b0;
		wbStb <= 1'b0;
		wbWe  <= 1'b0;
		@(posedge clock);
	endtask

	task automatic readWord(input logic [ADR_WIDTH-1:0] adr);
		cpuTransfer(1'b0, adr, '0, 1'b0, cachePkg::snoopRead, '0, 0);
	endtask

	task automatic writeWord(input logic [ADR_WIDTH-1:0] adr, input logic [DATA_WIDTH-1:0] data);
		cpuTransfer(1'b1, adr, data, 1'b0, cachePkg::snoopRead, '0, 0);
	endtask

	task automatic snoopTransfer(input cachePkg::snoopOp op, input logic [ADR_WIDTH-1:0] adr);
		int cycles;
		predictSnoop(op, adr);
		snoopValid <= 1'b1;
		snoopOpIn  <= op;
		snoopAdr   <= adr;
		@(posedge clock);
		snoopValid <= 1'b0;
		cycles = 0;
		@(negedge clock);
		while (!snoopDone && cycles < TIMEOUT) begin
			@(negedge clock);
			cycles++;
		end
		if (!snoopDone) begin
			$display("timeout: no snoopDone for address 0x%h", adr);
			timeoutCount++;
			snoopExpHit.delete();
			snoopExpData.delete();
		end
		@(posedge clock);
	endtask

	// responses are sampled mid-cycle
	always @(negedge clock) begin : compareResponses
		logic                  expAck;
		logic                  expCheck;
		logic                  expHit;
		logic [DATA_WIDTH-1:0] expData;
		if (rstN && (wbAck || wbErr)) begin
			if (cpuExpAck.size() == 0) begin
				$display("Wishbone response arrived with no request pending");
				errorCount++;
			end else begin
				expAck = cpuExpAck.pop_front();
				expCheck = cpuExpCheck.pop_front();
				expData = cpuExpData.pop_front();
				if (wbAck !== expAck) begin
					$display("FAILED wbAck: expected 0x%h, got 0x%h", expAck, wbAck);
					errorCount++;
				end
				if (wbErr !== !expAck) begin
					$display("FAILED wbErr: expected 0x%h, got 0x%h", !expAck, wbErr);
					errorCount++;
				end
				if (expCheck && wbDatR !== expData) begin
					$display("FAILED wbDatR: expected 0x%h, got 0x%h", expData, wbDatR);
					errorCount++;
				end
			end
		end
		if (rstN && snoopDone) begin
			if (snoopExpHit.size() == 0) begin
				$display("snoop response arrived with no snoop pending");
				errorCount++;
			end else begin
				expHit = snoopExpHit.pop_front();
				expData = snoopExpData.pop_front();
				if (snoopHit !== expHit) begin
					$display("FAILED snoopHit: expected 0x%h, got 0x%h", expHit, snoopHit);
					errorCount++;
				end else if (expHit && snoopData !== expData) begin
					$display("FAILED snoopData: expected 0x%h, got 0x%h", expData, snoopData);
					errorCount++;
				end
			end
		end
	end

	initial begin
		int                    choice;
		int                    missing;
		int                    hold;
		logic                  we;
		logic [ADR_WIDTH-1:0]  adr;
		logic [ADR_WIDTH-1:0]  otherAdr;
		logic [DATA_WIDTH-1:0] data;
		cachePkg::snoopOp      op;
		seed = 43;
		rstN       <= 1'b0;
		wbCyc      <= 1'b0;
		wbStb      <= 1'b0;
		wbWe       <= 1'b0;
		wbAdr      <= '0;
		wbDatW     <= '0;
		snoopValid <= 1'b0;
		snoopOpIn  <= cachePkg::snoopRead;
		snoopAdr   <= '0;
		resetModel();
		repeat (2) @(posedge clock);
		rstN <= 1'b1;
		@(posedge clock);

		// every set is empty after reset
		for (int s = 0; s < SETS; s++) begin
			readWord({TAG_WIDTH'(s * 5), INDEX_WIDTH'(s)});
		end

		writeWord({8'h11, 3'd2}, 32'hcafe_0102);
		readWord({8'h11, 3'd2});

		// third tag in set 5 evicts the first
		writeWord({8'h20, 3'd5}, 32'h2000_0005);
		writeWord({8'h21, 3'd5}, 32'h2100_0005);
		writeWord({8'h22, 3'd5}, 32'h2200_0005);
		readWord({8'h20, 3'd5});
		readWord({8'h21, 3'd5});
		readWord({8'h22, 3'd5});

		// a read in between keeps the first tag alive
		writeWord({8'h30, 3'd6}, 32'h3000_0006);
		writeWord({8'h31, 3'd6}, 32'h3100_0006);
		readWord({8'h30, 3'd6});
		writeWord({8'h32, 3'd6}, 32'h3200_0006);
		readWord({8'h30, 3'd6});
		readWord({8'h31, 3'd6});
		readWord({8'h32, 3'd6});

		// snoop read downgrades the line while cpu reads still hit
		writeWord({8'h40, 3'd1}, 32'h4000_0001);
		snoopTransfer(cachePkg::snoopRead, {8'h40, 3'd1});
		readWord({8'h40, 3'd1});
		writeWord({8'h40, 3'd1}, 32'h4000_1111);
		snoopTransfer(cachePkg::snoopRead, {8'h40, 3'd1});

		// invalidated way is the next victim
		writeWord({8'h50, 3'd3}, 32'h5000_0003);
		writeWord({8'h51, 3'd3}, 32'h5100_0003);
		readWord({8'h50, 3'd3});
		snoopTransfer(cachePkg::snoopInvalidate, {8'h50, 3'd3});
		readWord({8'h50, 3'd3});
		writeWord({8'h52, 3'd3}, 32'h5200_0003);
		readWord({8'h51, 3'd3});
		readWord({8'h52, 3'd3});

		for (int n = 0; n < 200; n++) begin
			choice = {$random(seed)} % 6;
			adr = randomAdr();
			data = $random(seed);
			we = ({$random(seed)} % 2) == 1;
			op = ({$random(seed)} % 2 == 0) ? cachePkg::snoopRead : cachePkg::snoopInvalidate;
			otherAdr = ({$random(seed)} % 2 == 0) ? adr : randomAdr();
			hold = {$random(seed)} % 3;
			case (choice)
				0, 1: begin
					readWord(adr);
				end
				2, 3: begin
					writeWord(adr, data);
				end
				4: begin
					snoopTransfer(op, adr);
				end
				default: begin
					// master holds stb while the snoop goes first
					cpuTransfer(we, adr, data, 1'b1, op, otherAdr, hold);
				end
			endcase
		end

		missing = cpuExpAck.size() + snoopExpHit.size();
		$display("errors: %0d mismatches, %0d timeouts, %0d missing responses",
			errorCount, timeoutCount, missing);
		if (errorCount == 0 && timeoutCount == 0 && missing == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
src/cachePkg.sv
src/cacheIf.sv
src/directMappedWay.sv
src/lruTracker.sv
src/setAssociativeCache.sv
src/cpuPort.sv
src/snoopPort.sv
src/cacheTop.sv
dv/cacheAssert.sv
dv/cacheTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = cacheTb
FILELIST = vlog.f
OBJDIR   = obj_dir
PASS_MSG = Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
